/* include/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and address width
`define CPU_XLEN 32

// Architectural registers x0 to x31
`define CPU_NUM_REGS 32

// Program counter after reset
`define CPU_RESET_PC 32'h0000_0000

// Fetching this word stops the core
`define CPU_HALT_WORD 32'h0000_00FF

`endif

/* hw/cpu_pkg.sv */
package cpu_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic {
    FETCH   = 1'b0,
    EXECUTE = 1'b1
  } state_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    PASS_B
  } alu_op_e;

  // Instruction formats, all 32 bits with the opcode in bits 6:0
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  // Branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_t;

endpackage

/* hw/register_file.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module register_file (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  cpu_pkg::instr_t                     i_instr,
  input  logic                                i_we,
  input  logic [`CPU_XLEN-1:0]                i_wdata,
  output logic [`CPU_XLEN-1:0]                o_rs1_data,
  output logic [`CPU_XLEN-1:0]                o_rs2_data,
  output logic [`CPU_NUM_REGS*`CPU_XLEN-1:0]  o_regs
);

  logic [`CPU_XLEN-1:0] r_regs [`CPU_NUM_REGS];

  // x0 is never written so it keeps its reset value of zero
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < `CPU_NUM_REGS; k++) begin
        r_regs[k] <= '0;
      end
    end else if (i_we && (i_instr.r.rd != 5'd0)) begin
      r_regs[i_instr.r.rd] <= i_wdata;
    end
  end

  // Operand reads straight from the IR fields
  assign o_rs1_data = r_regs[i_instr.r.rs1];
  assign o_rs2_data = r_regs[i_instr.r.rs2];

  // Flattened view, x0 in the lowest word
  for (genvar g = 0; g < `CPU_NUM_REGS; g++) begin : g_flat
    assign o_regs[g*`CPU_XLEN +: `CPU_XLEN] = r_regs[g];
  end

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module alu (
  input  cpu_pkg::state_e       i_state,
  input  cpu_pkg::instr_t       i_instr,
  input  logic [`CPU_XLEN-1:0]  i_rs1_data,
  input  logic [`CPU_XLEN-1:0]  i_rs2_data,
  input  logic [`CPU_XLEN-1:0]  i_pc,
  output logic                  o_alu_wb,
  output logic [`CPU_XLEN-1:0]  o_result,
  output logic [`CPU_XLEN-1:0]  o_jump_address,
  output logic                  o_jump_dv
);

  cpu_pkg::opcode_e      w_opcode;
  cpu_pkg::alu_op_e      w_alu_op;
  logic [`CPU_XLEN-1:0]  w_imm_i;
  logic [`CPU_XLEN-1:0]  w_imm_u;
  logic [`CPU_XLEN-1:0]  w_imm_b;
  logic [`CPU_XLEN-1:0]  w_imm_j;
  logic [`CPU_XLEN-1:0]  w_op_a;
  logic [`CPU_XLEN-1:0]  w_op_b;
  logic                  w_executing;
  logic                  w_branch_taken;

  assign w_opcode    = i_instr.r.opcode;
  assign w_executing = (i_state == cpu_pkg::EXECUTE);

  // Sign-extended immediates per format
  assign w_imm_i = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
  assign w_imm_u = {i_instr.u.imm, 12'b0};
  assign w_imm_b = {{20{i_instr.b.imm12}}, i_instr.b.imm11, i_instr.b.imm10_5,
                    i_instr.b.imm4_1, 1'b0};
  assign w_imm_j = {{12{i_instr.j.imm20}}, i_instr.j.imm19_12, i_instr.j.imm11,
                    i_instr.j.imm10_1, 1'b0};

  // Operation and operand selection
  always_comb begin
    w_alu_op = cpu_pkg::ADD;
    w_op_a   = i_rs1_data;
    w_op_b   = i_rs2_data;
    case (w_opcode)
      cpu_pkg::OP, cpu_pkg::OP_IMM: begin
        if (w_opcode == cpu_pkg::OP_IMM) begin
          w_op_b = w_imm_i;
        end
        case (i_instr.r.funct3)
          3'b000: begin
            // SUB only exists in the register form
            if ((w_opcode == cpu_pkg::OP) && i_instr.r.funct7[5]) begin
              w_alu_op = cpu_pkg::SUB;
            end else begin
              w_alu_op = cpu_pkg::ADD;
            end
          end
          3'b001:  w_alu_op = cpu_pkg::SLL;
          3'b010:  w_alu_op = cpu_pkg::SLT;
          3'b100:  w_alu_op = cpu_pkg::XOR;
          3'b101:  w_alu_op = cpu_pkg::SRL;
          3'b110:  w_alu_op = cpu_pkg::OR;
          3'b111:  w_alu_op = cpu_pkg::AND;
          default: w_alu_op = cpu_pkg::ADD;
        endcase
      end
      cpu_pkg::LUI: begin
        w_op_b   = w_imm_u;
        w_alu_op = cpu_pkg::PASS_B;
      end
      // Link value is PC+4
      cpu_pkg::JAL: begin
        w_op_a = i_pc;
        w_op_b = `CPU_XLEN'd4;
      end
      default: w_alu_op = cpu_pkg::ADD;
    endcase
  end

  always_comb begin
    case (w_alu_op)
      cpu_pkg::SUB:    o_result = w_op_a - w_op_b;
      cpu_pkg::AND:    o_result = w_op_a & w_op_b;
      cpu_pkg::OR:     o_result = w_op_a | w_op_b;
      cpu_pkg::XOR:    o_result = w_op_a ^ w_op_b;
      cpu_pkg::SLT:    o_result = {{(`CPU_XLEN-1){1'b0}}, $signed(w_op_a) < $signed(w_op_b)};
      cpu_pkg::SLL:    o_result = w_op_a << w_op_b[4:0];
      cpu_pkg::SRL:    o_result = w_op_a >> w_op_b[4:0];
      cpu_pkg::PASS_B: o_result = w_op_b;
      default:         o_result = w_op_a + w_op_b;
    endcase
  end

  // BEQ and BNE only
  always_comb begin
    case (i_instr.b.funct3)
      3'b000:  w_branch_taken = (i_rs1_data == i_rs2_data);
      3'b001:  w_branch_taken = (i_rs1_data != i_rs2_data);
      default: w_branch_taken = 1'b0;
    endcase
  end

  assign o_jump_address = i_pc + ((w_opcode == cpu_pkg::JAL) ? w_imm_j : w_imm_b);

  assign o_jump_dv = w_executing && ((w_opcode == cpu_pkg::JAL) ||
                     ((w_opcode == cpu_pkg::BRANCH) && w_branch_taken));

  assign o_alu_wb = w_executing && ((w_opcode == cpu_pkg::OP) ||
                    (w_opcode == cpu_pkg::OP_IMM) || (w_opcode == cpu_pkg::LUI) ||
                    (w_opcode == cpu_pkg::JAL));

endmodule

/* hw/load_store.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module load_store (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  cpu_pkg::state_e       i_state,
  input  cpu_pkg::instr_t       i_instr,
  input  logic                  i_start_fetch,
  input  logic [`CPU_XLEN-1:0]  i_pc,
  input  logic [`CPU_XLEN-1:0]  i_rs1_data,
  input  logic [`CPU_XLEN-1:0]  i_rs2_data,
  input  logic [`CPU_XLEN-1:0]  i_bus_data,
  input  logic                  i_bus_dv,
  output logic [`CPU_XLEN-1:0]  o_bus_data,
  output logic [`CPU_XLEN-1:0]  o_bus_address,
  output logic                  o_bus_dv,
  output logic                  o_write_notread,
  output logic [`CPU_XLEN-1:0]  o_ir_value,
  output logic                  o_ir_dv,
  output logic [`CPU_XLEN-1:0]  o_load_value,
  output logic                  o_load_dv,
  output logic                  o_ld_st_done
);

  logic                  r_busy;
  // Outstanding request is an instruction fetch
  logic                  r_fetch;
  logic                  r_bus_dv;
  logic                  r_write_notread;
  logic [`CPU_XLEN-1:0]  r_bus_address;
  logic [`CPU_XLEN-1:0]  r_bus_data;
  logic                  w_is_store;
  logic                  w_start_data;
  logic                  w_start_fetch;
  logic [`CPU_XLEN-1:0]  w_data_address;

  assign w_is_store = (i_instr.s.opcode == cpu_pkg::STORE);

  // Effective address is rs1 plus the I- or S-immediate
  assign w_data_address = i_rs1_data + (w_is_store ?
      {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo} :
      {{20{i_instr.i.imm[11]}}, i_instr.i.imm});

  assign w_start_fetch = i_start_fetch && !r_busy;
  assign w_start_data  = (i_state == cpu_pkg::EXECUTE) && !r_busy &&
                         ((i_instr.i.opcode == cpu_pkg::LOAD) || w_is_store);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_busy          <= 1'b0;
      r_fetch         <= 1'b0;
      r_bus_dv        <= 1'b0;
      r_write_notread <= 1'b0;
    end else begin
      r_bus_dv <= 1'b0;
      if (r_busy) begin
        if (i_bus_dv) begin
          r_busy          <= 1'b0;
          r_write_notread <= 1'b0;
        end
      end else if (w_start_fetch) begin
        r_busy          <= 1'b1;
        r_fetch         <= 1'b1;
        r_bus_dv        <= 1'b1;
        r_write_notread <= 1'b0;
      end else if (w_start_data) begin
        r_busy          <= 1'b1;
        r_fetch         <= 1'b0;
        r_bus_dv        <= 1'b1;
        r_write_notread <= w_is_store;
      end
    end
  end

  // Address and write data held for the whole request
  always_ff @(posedge i_clk) begin
    if (w_start_fetch) begin
      r_bus_address <= i_pc;
    end else if (w_start_data) begin
      r_bus_address <= w_data_address;
      r_bus_data    <= i_rs2_data;
    end
  end

  assign o_bus_dv        = r_bus_dv;
  assign o_bus_address   = r_bus_address;
  assign o_bus_data      = r_bus_data;
  assign o_write_notread = r_write_notread;

  // Route the response by request kind
  assign o_ir_value   = i_bus_data;
  assign o_ir_dv      = r_busy && r_fetch && i_bus_dv;
  assign o_load_value = i_bus_data;
  assign o_load_dv    = r_busy && !r_fetch && !r_write_notread && i_bus_dv;
  assign o_ld_st_done = r_busy && !r_fetch && i_bus_dv;

endmodule

/* hw/control_unit.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module control_unit (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [`CPU_XLEN-1:0]  i_ir_value,
  input  logic                  i_ir_dv,
  input  logic                  i_alu_wb,
  input  logic [`CPU_XLEN-1:0]  i_jump_address,
  input  logic                  i_jump_dv,
  input  logic                  i_ld_st_done,
  output cpu_pkg::state_e       o_state,
  output logic                  o_start_fetch,
  output cpu_pkg::instr_t       o_instr,
  output logic [`CPU_XLEN-1:0]  o_pc,
  output logic                  o_halted
);

  cpu_pkg::state_e       r_state;
  cpu_pkg::instr_t       r_instr;
  logic [`CPU_XLEN-1:0]  r_pc;
  logic                  r_halted;
  logic                  r_start_fetch;
  logic                  r_boot;
  logic                  w_exec_done;

  // End of EXECUTE, chosen by the opcode held in the IR
  always_comb begin
    case (r_instr.r.opcode)
      cpu_pkg::LOAD, cpu_pkg::STORE: w_exec_done = i_ld_st_done;
      cpu_pkg::OP, cpu_pkg::OP_IMM,
      cpu_pkg::LUI, cpu_pkg::JAL:    w_exec_done = i_alu_wb;
      // Branches and unknown words retire in one cycle
      default:                       w_exec_done = 1'b1;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_state       <= cpu_pkg::FETCH;
      r_instr       <= '0;
      r_pc          <= `CPU_RESET_PC;
      r_halted      <= 1'b0;
      r_start_fetch <= 1'b0;
      r_boot        <= 1'b1;
    end else begin
      // First fetch is kicked off one cycle after reset
      r_boot        <= 1'b0;
      r_start_fetch <= r_boot;

      case (r_state)
        cpu_pkg::FETCH: begin
          if (i_ir_dv) begin
            if (i_ir_value == `CPU_HALT_WORD) begin
              // Stay in FETCH with no further requests
              r_halted <= 1'b1;
            end else begin
              r_instr <= i_ir_value;
              r_state <= cpu_pkg::EXECUTE;
            end
          end
        end
        cpu_pkg::EXECUTE: begin
          if (w_exec_done) begin
            r_pc          <= i_jump_dv ? i_jump_address : r_pc + `CPU_XLEN'd4;
            r_state       <= cpu_pkg::FETCH;
            r_start_fetch <= 1'b1;
          end
        end
        default: r_state <= cpu_pkg::FETCH;
      endcase
    end
  end

  assign o_state       = r_state;
  assign o_start_fetch = r_start_fetch;
  assign o_instr       = r_instr;
  assign o_pc          = r_pc;
  assign o_halted      = r_halted;

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic [`CPU_XLEN-1:0]                  i_bus_data,
  input  logic                                  i_bus_dv,
  output logic [`CPU_XLEN-1:0]                  o_bus_data,
  output logic [`CPU_XLEN-1:0]                  o_bus_address,
  output logic                                  o_bus_dv,
  output logic                                  o_write_notread,
  output logic                                  o_halted,
  output logic [`CPU_XLEN-1:0]                  o_pc,
  output logic [`CPU_NUM_REGS*`CPU_XLEN-1:0]    o_regs
);

  // Sequencer
  cpu_pkg::state_e       w_state;
  cpu_pkg::instr_t       w_instr;
  logic                  w_start_fetch;
  logic [`CPU_XLEN-1:0]  w_pc;

  // Fetched word on its way to the instruction register
  logic [`CPU_XLEN-1:0]  w_ir_value;
  logic                  w_ir_dv;

  // ALU
  logic                  w_alu_wb;
  logic [`CPU_XLEN-1:0]  w_alu_result;
  logic [`CPU_XLEN-1:0]  w_jump_address;
  logic                  w_jump_dv;

  // Data access
  logic [`CPU_XLEN-1:0]  w_load_value;
  logic                  w_load_dv;
  logic                  w_ld_st_done;

  // Register file
  logic [`CPU_XLEN-1:0]  w_rs1_data;
  logic [`CPU_XLEN-1:0]  w_rs2_data;
  logic [`CPU_XLEN-1:0]  w_rf_wdata;
  logic                  w_rf_we;

  // Write back either the ALU result or the loaded word
  assign w_rf_wdata = w_alu_wb ? w_alu_result : w_load_value;
  assign w_rf_we    = w_alu_wb | w_load_dv;

  assign o_pc = w_pc;

  control_unit m_control_unit (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_ir_value     (w_ir_value),
    .i_ir_dv        (w_ir_dv),
    .i_alu_wb       (w_alu_wb),
    .i_jump_address (w_jump_address),
    .i_jump_dv      (w_jump_dv),
    .i_ld_st_done   (w_ld_st_done),
    .o_state        (w_state),
    .o_start_fetch  (w_start_fetch),
    .o_instr        (w_instr),
    .o_pc           (w_pc),
    .o_halted       (o_halted)
  );

  register_file m_register_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_instr    (w_instr),
    .i_we       (w_rf_we),
    .i_wdata    (w_rf_wdata),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .o_regs     (o_regs)
  );

  alu m_alu (
    .i_state        (w_state),
    .i_instr        (w_instr),
    .i_rs1_data     (w_rs1_data),
    .i_rs2_data     (w_rs2_data),
    .i_pc           (w_pc),
    .o_alu_wb       (w_alu_wb),
    .o_result       (w_alu_result),
    .o_jump_address (w_jump_address),
    .o_jump_dv      (w_jump_dv)
  );

  load_store m_load_store (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_state         (w_state),
    .i_instr         (w_instr),
    .i_start_fetch   (w_start_fetch),
    .i_pc            (w_pc),
    .i_rs1_data      (w_rs1_data),
    .i_rs2_data      (w_rs2_data),
    .i_bus_data      (i_bus_data),
    .i_bus_dv        (i_bus_dv),
    .o_bus_data      (o_bus_data),
    .o_bus_address   (o_bus_address),
    .o_bus_dv        (o_bus_dv),
    .o_write_notread (o_write_notread),
    .o_ir_value      (w_ir_value),
    .o_ir_dv         (w_ir_dv),
    .o_load_value    (w_load_value),
    .o_load_dv       (w_load_dv),
    .o_ld_st_done    (w_ld_st_done)
  );

endmodule

/* tb/mem_model.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module mem_model #(
  parameter int WORDS = 64
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_req_dv,
  input  logic                  i_write_notread,
  input  logic [`CPU_XLEN-1:0]  i_address,
  input  logic [`CPU_XLEN-1:0]  i_wdata,
  output logic                  o_rsp_dv,
  output logic [`CPU_XLEN-1:0]  o_rdata
);

  logic [`CPU_XLEN-1:0] mem_words [WORDS];
  int unsigned          store_count;

  // One request at a time, answered on a falling edge
  initial begin
    int unsigned          latency;
    int unsigned          word_index;
    logic                 is_write;
    logic [`CPU_XLEN-1:0] wdata;
    o_rsp_dv    = 1'b0;
    o_rdata     = '0;
    store_count = 0;
    // Seed the latency generator once
    latency     = $urandom(32'h401a);
    forever begin
      @(negedge i_clk);
      o_rsp_dv = 1'b0;
      if (!i_rst && i_req_dv) begin
        word_index = (i_address >> 2) % WORDS;
        is_write   = i_write_notread;
        wdata      = i_wdata;
        // Zero to five idle cycles before the answer
        latency    = $urandom % 6;
        repeat (latency) @(negedge i_clk);
        if (is_write) begin
          mem_words[word_index] = wdata;
          store_count++;
        end else begin
          o_rdata = mem_words[word_index];
        end
        o_rsp_dv = 1'b1;
      end
    end
  end

endmodule

/* tb/tb_cpu.sv */
`timescale 1ns/10ps
`include "cpu_macros.svh"

module tb_cpu;

  localparam int          IMAGE_WORDS  = 64;
  localparam int          REG_BASE     = 64;
  localparam int          DATA_BASE    = 96;
  localparam int          DATA_WORDS   = 8;
  localparam int          TEST_WORDS   = 104;
  localparam logic [31:0] DATA_ADDR    = 32'h0000_0080;
  localparam int          RESET_CYCLES = 5;
  localparam int          HALT_TIMEOUT = 2000;
  localparam int          QUIET_CYCLES = 50;

  logic                                i_clk;
  logic                                i_rst;
  logic [`CPU_XLEN-1:0]                i_bus_data;
  logic                                i_bus_dv;
  logic [`CPU_XLEN-1:0]                o_bus_data;
  logic [`CPU_XLEN-1:0]                o_bus_address;
  logic                                o_bus_dv;
  logic                                o_write_notread;
  logic                                o_halted;
  logic [`CPU_XLEN-1:0]                o_pc;
  logic [`CPU_NUM_REGS*`CPU_XLEN-1:0]  o_regs;

  // Image, expected registers, expected data words
  logic [`CPU_XLEN-1:0] tests [TEST_WORDS];
  int                   check_count;
  int                   mismatch_count;
  int                   failure_count;
  int                   stores_seen;
  logic                 halt_seen;

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  cpu_top u_dut (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_bus_data      (i_bus_data),
    .i_bus_dv        (i_bus_dv),
    .o_bus_data      (o_bus_data),
    .o_bus_address   (o_bus_address),
    .o_bus_dv        (o_bus_dv),
    .o_write_notread (o_write_notread),
    .o_halted        (o_halted),
    .o_pc            (o_pc),
    .o_regs          (o_regs)
  );

  mem_model #(
    .WORDS (IMAGE_WORDS)
  ) u_mem (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_req_dv        (o_bus_dv),
    .i_write_notread (o_write_notread),
    .i_address       (o_bus_address),
    .i_wdata         (o_bus_data),
    .o_rsp_dv        (i_bus_dv),
    .o_rdata         (i_bus_data)
  );

  // Every store must land in the data area with its final value
  always @(negedge i_clk) begin
    int unsigned slot;
    if (!i_rst && o_bus_dv) begin
      if ((o_bus_address >= IMAGE_WORDS * 4) || (o_bus_address[1:0] != 2'b00)) begin
        failure_count++;
        $display("Error at time %0t: bus request to 0x%08h is outside the memory image",
                 $time, o_bus_address);
      end
      if (o_write_notread) begin
        stores_seen++;
        check_count++;
        slot = (o_bus_address - DATA_ADDR) >> 2;
        if ((o_bus_address < DATA_ADDR) || (slot >= DATA_WORDS)) begin
          failure_count++;
          $display("Error at time %0t: store to 0x%08h is outside the data area",
                   $time, o_bus_address);
        end else if (o_bus_data !== tests[DATA_BASE + slot]) begin
          mismatch_count++;
          $display("Mismatch at time %0t: o_bus_data at 0x%08h expected 0x%08h actual 0x%08h",
                   $time, o_bus_address, tests[DATA_BASE + slot], o_bus_data);
        end
      end
    end
  end

  // Reset cycles plus the first cycle after release
  task automatic check_reset_phase();
    int cyc;
    for (cyc = 0; cyc <= RESET_CYCLES; cyc++) begin
      @(negedge i_clk);
      check_count += 3;
      if (o_bus_dv !== 1'b0) begin
        mismatch_count++;
        $display("Mismatch at time %0t: o_bus_dv expected 0 actual %b", $time, o_bus_dv);
      end
      if (o_halted !== 1'b0) begin
        mismatch_count++;
        $display("Mismatch at time %0t: o_halted expected 0 actual %b", $time, o_halted);
      end
      if (o_pc !== `CPU_RESET_PC) begin
        mismatch_count++;
        $display("Mismatch at time %0t: o_pc expected 0x%08h actual 0x%08h",
                 $time, `CPU_RESET_PC, o_pc);
      end
      if (cyc == RESET_CYCLES - 1) begin
        i_rst = 1'b0;
      end
    end
  endtask

  task automatic wait_for_halt();
    int cyc;
    cyc = 0;
    while (!halt_seen && (cyc < HALT_TIMEOUT)) begin
      @(negedge i_clk);
      cyc++;
      if (o_halted === 1'b1) begin
        halt_seen = 1'b1;
      end
    end
    if (!halt_seen) begin
      failure_count++;
      $display("Error at time %0t: core did not halt within %0d cycles", $time, HALT_TIMEOUT);
    end
  endtask

  // Halted core must stay silent on the bus
  task automatic check_quiet_bus();
    int cyc;
    for (cyc = 0; cyc < QUIET_CYCLES; cyc++) begin
      @(negedge i_clk);
      check_count += 2;
      if (o_bus_dv !== 1'b0) begin
        mismatch_count++;
        $display("Mismatch at time %0t: o_bus_dv after halt expected 0 actual %b",
                 $time, o_bus_dv);
      end
      if (o_halted !== 1'b1) begin
        mismatch_count++;
        $display("Mismatch at time %0t: o_halted expected 1 actual %b", $time, o_halted);
      end
    end
  endtask

  task automatic check_registers();
    int                   r;
    logic [`CPU_XLEN-1:0] actual;
    for (r = 0; r < `CPU_NUM_REGS; r++) begin
      actual = o_regs[r*`CPU_XLEN +: `CPU_XLEN];
      check_count++;
      if (actual !== tests[REG_BASE + r]) begin
        mismatch_count++;
        $display("Mismatch at time %0t: o_regs x%0d expected 0x%08h actual 0x%08h",
                 $time, r, tests[REG_BASE + r], actual);
      end
    end
  endtask

  task automatic check_memory();
    int                   k;
    logic [`CPU_XLEN-1:0] actual;
    for (k = 0; k < DATA_WORDS; k++) begin
      actual = u_mem.mem_words[DATA_ADDR / 4 + k];
      check_count++;
      if (actual !== tests[DATA_BASE + k]) begin
        mismatch_count++;
        $display("Mismatch at time %0t: memory word 0x%08h expected 0x%08h actual 0x%08h",
                 $time, DATA_ADDR + 4 * k, tests[DATA_BASE + k], actual);
      end
    end
    check_count++;
    if (stores_seen == 0) begin
      failure_count++;
      $display("Error at time %0t: no store was seen on the bus", $time);
    end else if (stores_seen != u_mem.store_count) begin
      mismatch_count++;
      $display("Mismatch at time %0t: store_count expected %0d actual %0d",
               $time, stores_seen, u_mem.store_count);
    end
  endtask

  initial begin
    int k;
    check_count    = 0;
    mismatch_count = 0;
    failure_count  = 0;
    stores_seen    = 0;
    halt_seen      = 1'b0;
    i_rst          = 1'b1;

    $readmemh("tb/cpu_tests.hex", tests);
    if (tests[TEST_WORDS-1] === {`CPU_XLEN{1'bx}}) begin
      failure_count++;
      $display("Error: test file tb/cpu_tests.hex was not loaded completely");
    end
    for (k = 0; k < IMAGE_WORDS; k++) begin
      u_mem.mem_words[k] = tests[k];
    end

    check_reset_phase();
    wait_for_halt();
    if (halt_seen) begin
      check_quiet_bus();
      check_registers();
      check_memory();
    end

    $display("Checks: %0d, mismatches: %0d, other failures: %0d",
             check_count, mismatch_count, failure_count);
    if ((mismatch_count == 0) && (failure_count == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tb/cpu_tests.hex */
// Words 0-63 memory image, 64-95 expected x0-x31, 96-103 expected words at 0x80-0x9C
// Eight words per line, lowest address first
// 0x00 lui, addi, addi, add, sub, andi, or, xori
123450B7 FFB00113 12300193 00308233 402182B3 0FF27313 0030E3B3 FFF24413
// 0x20 slt, slti, slli, srli, lw, lw, add, addi
003124B3 FFB1A513 00419593 01C15613 08002683 08402703 00E687B3 08000813
// 0x40 sw, sw, beq taken, skipped addi, bne not taken, addi, jal, skipped addi
00F82423 00582E23 00318463 00100893 00319463 00200913 008009EF 00300A13
// 0x60 addi to x0, lw, halt
00500013 08802A83 000000FF 00000000 00000000 00000000 00000000 00000000
// Data area 0x80-0x9C
00001111 22220000 DEADBEEF 0BADF00D 55AA55AA 01234567 89ABCDEF CAFEF00D
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// Expected x0-x31
00000000 12345000 FFFFFFFB 00000123 12345123 00000128 00000023 12345123
EDCBAEDC 00000001 00000000 00001230 0000000F 00001111 22220000 22221111
00000080 00000000 00000002 0000005C 00000000 22221111 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// Expected data words 0x80-0x9C
00001111 22220000 22221111 0BADF00D 55AA55AA 01234567 89ABCDEF 00000128

/* tb.f */
+incdir+include
hw/cpu_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/load_store.sv
hw/control_unit.sv
hw/cpu_top.sv
tb/mem_model.sv
tb/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu_multicycle

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/cpu_pkg.sv
      - hw/register_file.sv
      - hw/alu.sv
      - hw/load_store.sv
      - hw/control_unit.sv
      - hw/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/mem_model.sv
      - tb/tb_cpu.sv
